// File: vertex_job_pkg.sv
// Shared types for the vertex job stage
// Record and job field positions, table size and register map
// Fetch state encoding

package vertex_job_pkg;

	//////////////////////////////////////////////////
	// Field types
	//////////////////////////////////////////////////

	// Index into the vertex table
	typedef logic [7:0] vertex_id_t;
	// Inverse out-degree, zero when no outgoing edges
	typedef logic [15:0] degree_t;
	// MSB set while unvisited, low bits hold the parent id
	typedef logic [8:0] parent_t;
	// Job counters and programmed vertex count
	typedef logic [15:0] count_t;
	typedef logic [1:0] reg_addr_t;

	// Table record, degree sits above parent
	typedef logic [$bits(degree_t)+$bits(parent_t)-1:0] vertex_record_t;
	// Job word, vertex id above the record
	typedef logic [$bits(vertex_id_t)+$bits(vertex_record_t)-1:0] vertex_job_t;

	// Table size and field offsets
	localparam int VERTEX_TABLE_DEPTH = 2 ** $bits(vertex_id_t);
	localparam int PARENT_LSB = 0;
	localparam int DEGREE_LSB = PARENT_LSB + $bits(parent_t);
	localparam int PARENT_UNVISITED_BIT = $bits(parent_t) - 1;

	//////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////

	localparam reg_addr_t REG_CONTROL = 2'd0;
	localparam reg_addr_t REG_VERTEX_COUNT = 2'd1;
	localparam reg_addr_t REG_STATUS = 2'd2;
	localparam reg_addr_t REG_FILTERED = 2'd3;

	// CONTROL and STATUS bits
	localparam int CONTROL_ENABLE_BIT = 0;
	localparam int CONTROL_START_BIT = 1;
	localparam int STATUS_ENABLE_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

	// Fetch engine states
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_READ,
		FETCH_ISSUE,
		FETCH_DONE
	} fetch_state_t;

endpackage

// File: vertex_table.sv
// Vertex record memory
// Host write port and one-cycle registered read port

`timescale 1ns/100ps

module vertex_table (
	input  logic                           clock,
	// Host write strobe
	input  logic                           table_write,
	input  vertex_job_pkg::vertex_id_t     table_addr,
	input  vertex_job_pkg::vertex_record_t table_wdata,
	// Fetch read side
	input  logic                           read_enable,
	input  vertex_job_pkg::vertex_id_t     read_addr,
	output vertex_job_pkg::vertex_record_t read_data
);

	// One record per vertex id
	vertex_job_pkg::vertex_record_t records [vertex_job_pkg::VERTEX_TABLE_DEPTH];

	//////////////////////////////////////////////////
	// Host write
	//////////////////////////////////////////////////

	// Single write per cycle from the host
	always_ff @(posedge clock) begin
		if (table_write) begin
			records[table_addr] <= table_wdata;
		end
	end

	//////////////////////////////////////////////////
	// Registered read
	//////////////////////////////////////////////////

	// Data valid the cycle after read_enable
	// Holds last record while no read is issued
	always_ff @(posedge clock) begin
		if (read_enable) begin
			read_data <= records[read_addr];
		end
	end

endmodule

// File: vertex_job_fifo.sv
// Synchronous FIFO
// Circular buffer with occupancy count, full, almost-full and empty
// Registered output with a valid strobe per pop

`timescale 1ns/100ps

module vertex_job_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16,
	parameter int ALMOST_FULL_MARGIN = 4
) (
	input  logic             clock,
	input  logic             rstn,
	// Write side
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             almost_full,
	// Read side
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             out_valid,
	output logic             empty
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] storage [DEPTH];
	logic [PTR_WIDTH-1:0] write_ptr;
	logic [PTR_WIDTH-1:0] read_ptr;
	logic [COUNT_WIDTH-1:0] occupancy;
	logic do_push;
	logic do_pop;

	// Pointer step with wrap at the last entry
	function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	//////////////////////////////////////////////////
	// Status flags
	//////////////////////////////////////////////////

	assign full = (occupancy == COUNT_WIDTH'(DEPTH));
	assign empty = (occupancy == '0);
	// Early warning, margin left for jobs still in flight
	assign almost_full = (occupancy >= COUNT_WIDTH'(DEPTH - ALMOST_FULL_MARGIN));

	// Push on full and pop on empty are ignored
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_ptr <= '0;
			read_ptr <= '0;
			occupancy <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= do_pop;
			if (do_push) begin
				write_ptr <= ptr_next(write_ptr);
			end
			if (do_pop) begin
				read_ptr <= ptr_next(read_ptr);
			end
			case ({do_push, do_pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			storage[write_ptr] <= data_in;
		end
		// Output word lands with out_valid
		if (do_pop) begin
			data_out <= storage[read_ptr];
		end
	end

endmodule

// File: vertex_job_filter.sv
// Vertex job filter
// Input and output registers, keep or drop rule, filtered counter
// Job buffer serving consumer requests

`timescale 1ns/100ps

module vertex_job_filter #(
	parameter int JOB_BUFFER_DEPTH = 16,
	parameter int ALMOST_FULL_MARGIN = 4
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enable,
	// Jobs from fetch
	input  logic                        job_valid,
	input  vertex_job_pkg::vertex_job_t job_data,
	// Consumer side
	input  logic                        vertex_request,
	output logic                        job_throttle,
	output logic                        vertex_out_valid,
	output vertex_job_pkg::vertex_job_t vertex_out,
	output vertex_job_pkg::count_t      filtered_count
);

	// Input registers
	logic job_valid_q;
	vertex_job_pkg::vertex_job_t job_q;
	logic request_q;

	// Rule terms
	vertex_job_pkg::degree_t job_degree;
	vertex_job_pkg::parent_t job_parent;
	logic job_wanted;
	logic keep_job;
	logic drop_job;
	vertex_job_pkg::count_t drop_counter;

	// Job buffer
	logic buffer_push;
	logic buffer_pop;
	logic buffer_full;
	logic buffer_almost_full;
	logic buffer_empty;
	logic buffer_out_valid;
	vertex_job_pkg::vertex_job_t buffer_data;

	//////////////////////////////////////////////////
	// Input registers
	//////////////////////////////////////////////////

	// Held while disabled, captured on the next enabled edge
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_valid_q <= 1'b0;
			request_q <= 1'b0;
		end else if (enable) begin
			job_valid_q <= job_valid;
			request_q <= vertex_request;
		end
	end

	always_ff @(posedge clock) begin
		if (enable) begin
			job_q <= job_data;
		end
	end

	//////////////////////////////////////////////////
	// Filter rule
	//////////////////////////////////////////////////

	assign job_degree = job_q[vertex_job_pkg::DEGREE_LSB +: $bits(vertex_job_pkg::degree_t)];
	assign job_parent = job_q[vertex_job_pkg::PARENT_LSB +: $bits(vertex_job_pkg::parent_t)];

	// Keep only unvisited vertices with outgoing edges
	assign job_wanted = (|job_degree) && job_parent[vertex_job_pkg::PARENT_UNVISITED_BIT];
	// Decided once, on an enabled edge
	assign keep_job = enable && job_valid_q && job_wanted;
	assign drop_job = enable && job_valid_q && !job_wanted;

	// Cleared only by reset
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			drop_counter <= '0;
		end else if (drop_job) begin
			drop_counter <= drop_counter + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Job buffer
	//////////////////////////////////////////////////

	assign buffer_push = keep_job && !buffer_full;
	// Registered request drains one job per cycle
	assign buffer_pop = enable && request_q && !buffer_empty;

	vertex_job_fifo #(
		.WIDTH             ($bits(vertex_job_pkg::vertex_job_t)),
		.DEPTH             (JOB_BUFFER_DEPTH),
		.ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
	) job_buffer (
		.clock      (clock),
		.rstn       (rstn),
		.push       (buffer_push),
		.data_in    (job_q),
		.full       (buffer_full),
		.almost_full(buffer_almost_full),
		.pop        (buffer_pop),
		.data_out   (buffer_data),
		.out_valid  (buffer_out_valid),
		.empty      (buffer_empty)
	);

	//////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////

	// Throttle and count frozen while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_throttle <= 1'b0;
			filtered_count <= '0;
		end else if (enable) begin
			job_throttle <= buffer_almost_full;
			filtered_count <= drop_counter;
		end
	end

	// One strobe per pop, so a job popped as enable falls still leaves
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_out_valid <= 1'b0;
		end else begin
			vertex_out_valid <= buffer_out_valid;
		end
	end

	always_ff @(posedge clock) begin
		vertex_out <= buffer_data;
	end

endmodule

// File: vertex_job_config.sv
// Host register block
// Enable and vertex count registers, start pulse
// Status and filtered count read back

`timescale 1ns/100ps

module vertex_job_config (
	input  logic                      clock,
	input  logic                      rstn,
	// Host register port
	input  logic                      reg_write,
	input  vertex_job_pkg::reg_addr_t reg_addr,
	input  logic [31:0]               reg_wdata,
	output logic [31:0]               reg_rdata,
	// Status from the stages
	input  logic                      fetch_done,
	input  vertex_job_pkg::count_t    filtered_count,
	// Control to the stages
	output logic                      enable,
	output logic                      start_pulse,
	output vertex_job_pkg::count_t    vertex_count
);

	logic control_write;
	logic count_write;

	// Address decode for writes
	assign control_write = reg_write && (reg_addr == vertex_job_pkg::REG_CONTROL);
	assign count_write = reg_write && (reg_addr == vertex_job_pkg::REG_VERTEX_COUNT);

	//////////////////////////////////////////////////
	// Writable registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable <= 1'b0;
			start_pulse <= 1'b0;
			vertex_count <= '0;
		end else begin
			// Start bit is self clearing, one cycle only
			start_pulse <= control_write && reg_wdata[vertex_job_pkg::CONTROL_START_BIT];
			if (control_write) begin
				enable <= reg_wdata[vertex_job_pkg::CONTROL_ENABLE_BIT];
			end
			if (count_write) begin
				vertex_count <= reg_wdata[$bits(vertex_job_pkg::count_t)-1:0];
			end
		end
	end

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////

	// Combinational from reg_addr, unused bits read zero
	always_comb begin
		reg_rdata = '0;
		case (reg_addr)
			vertex_job_pkg::REG_CONTROL: begin
				reg_rdata[vertex_job_pkg::CONTROL_ENABLE_BIT] = enable;
			end
			vertex_job_pkg::REG_VERTEX_COUNT: begin
				reg_rdata[$bits(vertex_job_pkg::count_t)-1:0] = vertex_count;
			end
			vertex_job_pkg::REG_STATUS: begin
				reg_rdata[vertex_job_pkg::STATUS_ENABLE_BIT] = enable;
				reg_rdata[vertex_job_pkg::STATUS_DONE_BIT] = fetch_done;
			end
			vertex_job_pkg::REG_FILTERED: begin
				reg_rdata[$bits(vertex_job_pkg::count_t)-1:0] = filtered_count;
			end
		endcase
	end

endmodule

// File: vertex_job_fetch.sv
// Fetch engine
// Walks vertex ids through the table and issues one job per two cycles
// Throttled by the job buffer almost-full level

`timescale 1ns/100ps

module vertex_job_fetch (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enable,
	input  logic                           start_pulse,
	input  vertex_job_pkg::count_t         vertex_count,
	input  logic                           job_throttle,
	// Table read side
	output logic                           read_enable,
	output vertex_job_pkg::vertex_id_t     read_addr,
	input  vertex_job_pkg::vertex_record_t read_data,
	// Job strobe to the filter
	output logic                           job_valid,
	output vertex_job_pkg::vertex_job_t    job_data,
	output logic                           fetch_done
);

	vertex_job_pkg::fetch_state_t state;
	// Jobs issued so far in this run
	vertex_job_pkg::count_t job_index;
	vertex_job_pkg::count_t next_index;
	// Id of the record in flight from the table
	vertex_job_pkg::vertex_id_t read_id;
	logic issue_job;
	logic last_job;

	//////////////////////////////////////////////////
	// Table read and issue decode
	//////////////////////////////////////////////////

	// No new read while paused or throttled
	assign read_enable = enable && !job_throttle && (state == vertex_job_pkg::FETCH_READ);
	assign read_addr = job_index[$bits(vertex_job_pkg::vertex_id_t)-1:0];

	// Record arrives one cycle after the read, paired here
	assign issue_job = enable && (state == vertex_job_pkg::FETCH_ISSUE);
	assign next_index = job_index + 16'd1;
	assign last_job = (next_index == vertex_count);

	//////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= vertex_job_pkg::FETCH_IDLE;
			job_index <= '0;
			job_valid <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			// Strobe clears on the next active edge, holds while paused
			if (enable) begin
				job_valid <= 1'b0;
			end
			case (state)
				vertex_job_pkg::FETCH_IDLE: begin
					// Start is taken even before enable is set
					if (start_pulse) begin
						job_index <= '0;
						fetch_done <= 1'b0;
						if (vertex_count == '0) begin
							state <= vertex_job_pkg::FETCH_DONE;
						end else begin
							state <= vertex_job_pkg::FETCH_READ;
						end
					end
				end
				vertex_job_pkg::FETCH_READ: begin
					if (read_enable) begin
						state <= vertex_job_pkg::FETCH_ISSUE;
					end
				end
				vertex_job_pkg::FETCH_ISSUE: begin
					if (issue_job) begin
						job_valid <= 1'b1;
						job_index <= next_index;
						if (last_job) begin
							state <= vertex_job_pkg::FETCH_DONE;
						end else begin
							state <= vertex_job_pkg::FETCH_READ;
						end
					end
				end
				vertex_job_pkg::FETCH_DONE: begin
					// Level held until the next start
					if (enable) begin
						fetch_done <= 1'b1;
						state <= vertex_job_pkg::FETCH_IDLE;
					end
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Payload
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (read_enable) begin
			read_id <= read_addr;
		end
		if (issue_job) begin
			job_data <= {read_id, read_data};
		end
	end

endmodule

// File: vertex_job_unit.sv
// Vertex job stage top level
// Table, register block, fetch engine and filter

`timescale 1ns/100ps

module vertex_job_unit #(
	parameter int JOB_BUFFER_DEPTH = 16,
	parameter int ALMOST_FULL_MARGIN = 4
) (
	input  logic                           clock,
	input  logic                           rstn,
	// Host register port
	input  logic                           reg_write,
	input  vertex_job_pkg::reg_addr_t      reg_addr,
	input  logic [31:0]                    reg_wdata,
	output logic [31:0]                    reg_rdata,
	// Host table port
	input  logic                           table_write,
	input  vertex_job_pkg::vertex_id_t     table_addr,
	input  vertex_job_pkg::vertex_record_t table_wdata,
	// Consumer port
	input  logic                           vertex_request,
	output logic                           vertex_out_valid,
	output vertex_job_pkg::vertex_job_t    vertex_out
);

	// Config to stages
	logic enable;
	logic start_pulse;
	vertex_job_pkg::count_t vertex_count;
	// Status back to config
	logic fetch_done;
	vertex_job_pkg::count_t filtered_count;
	// Fetch and table
	logic read_enable;
	vertex_job_pkg::vertex_id_t read_addr;
	vertex_job_pkg::vertex_record_t read_data;
	// Fetch and filter
	logic job_valid;
	vertex_job_pkg::vertex_job_t job_data;
	logic job_throttle;

	vertex_table table_inst (
		.clock      (clock),
		.table_write(table_write),
		.table_addr (table_addr),
		.table_wdata(table_wdata),
		.read_enable(read_enable),
		.read_addr  (read_addr),
		.read_data  (read_data)
	);

	vertex_job_config config_inst (
		.clock         (clock),
		.rstn          (rstn),
		.reg_write     (reg_write),
		.reg_addr      (reg_addr),
		.reg_wdata     (reg_wdata),
		.reg_rdata     (reg_rdata),
		.fetch_done    (fetch_done),
		.filtered_count(filtered_count),
		.enable        (enable),
		.start_pulse   (start_pulse),
		.vertex_count  (vertex_count)
	);

	vertex_job_fetch fetch_inst (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.start_pulse (start_pulse),
		.vertex_count(vertex_count),
		.job_throttle(job_throttle),
		.read_enable (read_enable),
		.read_addr   (read_addr),
		.read_data   (read_data),
		.job_valid   (job_valid),
		.job_data    (job_data),
		.fetch_done  (fetch_done)
	);

	vertex_job_filter #(
		.JOB_BUFFER_DEPTH  (JOB_BUFFER_DEPTH),
		.ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
	) filter_inst (
		.clock           (clock),
		.rstn            (rstn),
		.enable          (enable),
		.job_valid       (job_valid),
		.job_data        (job_data),
		.vertex_request  (vertex_request),
		.job_throttle    (job_throttle),
		.vertex_out_valid(vertex_out_valid),
		.vertex_out      (vertex_out),
		.filtered_count  (filtered_count)
	);

endmodule

// File: vertex_job_tb.sv
// Testbench for the vertex job stage
// Host register and table tasks, consumer model
// Reference queue of kept jobs, output and register checks

`timescale 1ns/100ps

module vertex_job_tb;

	localparam int JOB_BUFFER_DEPTH = 16;
	localparam int ALMOST_FULL_MARGIN = 4;
	localparam int TABLE_ENTRIES = 128;

	// DUT ports
	logic clock;
	logic rstn;
	logic reg_write;
	vertex_job_pkg::reg_addr_t reg_addr;
	logic [31:0] reg_wdata;
	logic [31:0] reg_rdata;
	logic table_write;
	vertex_job_pkg::vertex_id_t table_addr;
	vertex_job_pkg::vertex_record_t table_wdata;
	logic vertex_request;
	logic vertex_out_valid;
	vertex_job_pkg::vertex_job_t vertex_out;

	// Reference model
	vertex_job_pkg::vertex_record_t table_model [TABLE_ENTRIES];
	vertex_job_pkg::vertex_job_t expected_jobs [$];
	vertex_job_pkg::vertex_job_t head_job;
	int total_drops;
	int run_kept;
	int run_drops;
	int run_count;
	int outputs_at_start;
	int total_outputs;
	// FILTERED as read back at the end of the previous run
	int filtered_before;
	logic output_blocked;
	integer seed;

	// Error counters, one set per process
	int host_value_errors;
	int host_other_errors;
	int output_value_errors;
	int output_other_errors;

	vertex_job_unit #(
		.JOB_BUFFER_DEPTH  (JOB_BUFFER_DEPTH),
		.ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
	) uut (
		.clock           (clock),
		.rstn            (rstn),
		.reg_write       (reg_write),
		.reg_addr        (reg_addr),
		.reg_wdata       (reg_wdata),
		.reg_rdata       (reg_rdata),
		.table_write     (table_write),
		.table_addr      (table_addr),
		.table_wdata     (table_wdata),
		.vertex_request  (vertex_request),
		.vertex_out_valid(vertex_out_valid),
		.vertex_out      (vertex_out)
	);

	// 4 ns period
	initial clock = 1'b0;
	always #2 clock = ~clock;

	//////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		// Quiet while in reset
		if (!rstn) begin
			assert (vertex_out_valid == 1'b0) else begin
				output_value_errors++;
				$display("ERR %0.1f ns: vertex_out_valid expected 0 got 1", $realtime);
			end
		end
		// Nothing may leave once the disable window has drained
		if (output_blocked) begin
			assert (vertex_out_valid == 1'b0) else begin
				output_value_errors++;
				$display("ERR %0.1f ns: vertex_out_valid expected 0 got 1", $realtime);
			end
		end
		if (rstn && vertex_out_valid) begin
			total_outputs++;
			if (expected_jobs.size() == 0) begin
				output_other_errors++;
				$display("%0.1f ns: job %h came out with no kept job outstanding",
					$realtime, vertex_out);
			end else begin
				// Kept jobs leave in id order, record untouched
				head_job = expected_jobs.pop_front();
				assert (vertex_out == head_job) else begin
					output_value_errors++;
					$display("ERR %0.1f ns: vertex_out expected %h got %h",
						$realtime, head_job, vertex_out);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Host tasks
	//////////////////////////////////////////////////

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clock);
			#0.5;
		end
	endtask

	// One-cycle write strobe
	task automatic write_register(input vertex_job_pkg::reg_addr_t addr, input logic [31:0] data);
		@(posedge clock);
		#0.5;
		reg_write = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(posedge clock);
		#0.5;
		reg_write = 1'b0;
	endtask

	// Read mux is combinational, sampled mid cycle
	task automatic read_register(input vertex_job_pkg::reg_addr_t addr, output logic [31:0] data);
		@(posedge clock);
		#0.5;
		reg_addr = addr;
		#1;
		data = reg_rdata;
	endtask

	task automatic check_register(input vertex_job_pkg::reg_addr_t addr,
		input logic [31:0] expected, input string name);
		logic [31:0] value;
		read_register(addr, value);
		assert (value == expected) else begin
			host_value_errors++;
			$display("ERR %0.1f ns: reg_rdata(%s) expected %h got %h",
				$realtime, name, expected, value);
		end
	endtask

	task automatic write_table_entry(input vertex_job_pkg::vertex_id_t id,
		input vertex_job_pkg::vertex_record_t record);
		@(posedge clock);
		#0.5;
		table_write = 1'b1;
		table_addr = id;
		table_wdata = record;
		@(posedge clock);
		#0.5;
		table_write = 1'b0;
	endtask

	// Random records, some with zero degree, some already visited
	task automatic load_table();
		logic [31:0] random_word;
		logic [31:0] shape;
		vertex_job_pkg::vertex_record_t record;
		for (int i = 0; i < TABLE_ENTRIES; i++) begin
			random_word = $random(seed);
			shape = $random(seed);
			record = random_word[24:0];
			if (shape[2:0] == 3'd0) begin
				record[24:9] = 16'd0;
			end
			// Roughly three in four left unvisited
			record[8] = (shape[5:4] != 2'b00);
			table_model[i] = record;
			write_table_entry(vertex_job_pkg::vertex_id_t'(i), record);
		end
	endtask

	//////////////////////////////////////////////////
	// Reference rule and run control
	//////////////////////////////////////////////////

	// Degree in bits 24:9, unvisited flag in bit 8
	function automatic logic record_kept(input vertex_job_pkg::vertex_record_t record);
		return (record[24:9] != 16'd0) && record[8];
	endfunction

	task automatic start_run(input int count);
		vertex_job_pkg::vertex_record_t record;
		run_kept = 0;
		run_drops = 0;
		for (int id = 0; id < count; id++) begin
			record = table_model[id];
			if (record_kept(record)) begin
				expected_jobs.push_back({vertex_job_pkg::vertex_id_t'(id), record});
				run_kept++;
			end else begin
				run_drops++;
			end
		end
		// FILTERED is never cleared between runs
		total_drops += run_drops;
		run_count = count;
		outputs_at_start = total_outputs;
		write_register(vertex_job_pkg::REG_VERTEX_COUNT, 32'(count));
		check_register(vertex_job_pkg::REG_VERTEX_COUNT, 32'(count), "VERTEX_COUNT");
		// Enable plus start
		write_register(vertex_job_pkg::REG_CONTROL, 32'h3);
		check_register(vertex_job_pkg::REG_CONTROL, 32'h1, "CONTROL");
	endtask

	task automatic await_fetch_done(input int limit);
		logic [31:0] status;
		int cycles;
		status = '0;
		cycles = 0;
		while (status[vertex_job_pkg::STATUS_DONE_BIT] != 1'b1 && cycles < limit) begin
			read_register(vertex_job_pkg::REG_STATUS, status);
			cycles++;
		end
		if (status[vertex_job_pkg::STATUS_DONE_BIT] != 1'b1) begin
			host_other_errors++;
			$display("%0.1f ns: fetch_done never showed in STATUS within %0d cycles",
				$realtime, limit);
		end
	endtask

	task automatic drain_outputs(input int limit);
		int cycles;
		cycles = 0;
		while (expected_jobs.size() != 0 && cycles < limit) begin
			idle_cycles(1);
			cycles++;
		end
		if (expected_jobs.size() != 0) begin
			host_other_errors++;
			$display("%0.1f ns: %0d kept jobs still missing after %0d cycles",
				$realtime, expected_jobs.size(), limit);
		end
	endtask

	task automatic await_outputs(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (total_outputs < target && cycles < limit) begin
			idle_cycles(1);
			cycles++;
		end
		if (total_outputs < target) begin
			host_other_errors++;
			$display("%0.1f ns: only %0d of %0d outputs seen within %0d cycles",
				$realtime, total_outputs, target, limit);
		end
	endtask

	// Counter lags the last drop by a few cycles
	task automatic poll_filtered(input int expected, input int limit,
		output logic [31:0] value);
		int cycles;
		value = '0;
		cycles = 0;
		read_register(vertex_job_pkg::REG_FILTERED, value);
		while (value != 32'(expected) && cycles < limit) begin
			read_register(vertex_job_pkg::REG_FILTERED, value);
			cycles++;
		end
		assert (value == 32'(expected)) else begin
			host_value_errors++;
			$display("ERR %0.1f ns: reg_rdata(FILTERED) expected %h got %h",
				$realtime, 32'(expected), value);
		end
	endtask

	task automatic check_run_totals();
		logic [31:0] filtered_now;
		int run_outputs;
		int counted_drops;
		poll_filtered(total_drops, 20, filtered_now);
		run_outputs = total_outputs - outputs_at_start;
		// Drops of this run as counted by the DUT
		counted_drops = int'(filtered_now) - filtered_before;
		filtered_before = int'(filtered_now);
		assert (run_outputs == run_kept) else begin
			host_value_errors++;
			$display("ERR %0.1f ns: output count expected %0d got %0d",
				$realtime, run_kept, run_outputs);
		end
		assert (run_outputs + counted_drops == run_count) else begin
			host_value_errors++;
			$display("ERR %0.1f ns: outputs plus FILTERED drops expected %0d got %0d",
				$realtime, run_count, run_outputs + counted_drops);
		end
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		seed = 99345;
		rstn = 1'b0;
		reg_write = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		table_write = 1'b0;
		table_addr = '0;
		table_wdata = '0;
		vertex_request = 1'b0;
		output_blocked = 1'b0;
		total_drops = 0;
		total_outputs = 0;
		filtered_before = 0;
		host_value_errors = 0;
		host_other_errors = 0;
		output_value_errors = 0;
		output_other_errors = 0;

		repeat (5) @(posedge clock);
		#0.5;
		rstn = 1'b1;

		// Clean state after reset
		assert (vertex_out_valid == 1'b0) else begin
			host_value_errors++;
			$display("ERR %0.1f ns: vertex_out_valid expected 0 got 1", $realtime);
		end
		check_register(vertex_job_pkg::REG_FILTERED, 32'h0, "FILTERED");
		check_register(vertex_job_pkg::REG_STATUS, 32'h0, "STATUS");

		load_table();

		// Consumer always requesting
		vertex_request = 1'b1;
		start_run(60);
		await_fetch_done(1000);
		drain_outputs(200);
		check_run_totals();

		// Back-pressure, consumer stalls for 200 cycles
		vertex_request = 1'b0;
		start_run(120);
		if (run_kept <= JOB_BUFFER_DEPTH) begin
			host_other_errors++;
			$display("Back-pressure run keeps only %0d jobs, buffer never fills", run_kept);
		end
		idle_cycles(200);
		vertex_request = 1'b1;
		await_fetch_done(3000);
		drain_outputs(400);
		check_run_totals();

		// Enable cleared mid run, then set again
		start_run(80);
		await_outputs(outputs_at_start + 10, 500);
		write_register(vertex_job_pkg::REG_CONTROL, 32'h0);
		check_register(vertex_job_pkg::REG_CONTROL, 32'h0, "CONTROL");
		// Short window for jobs already popped
		idle_cycles(4);
		output_blocked = 1'b1;
		idle_cycles(50);
		output_blocked = 1'b0;
		write_register(vertex_job_pkg::REG_CONTROL, 32'h1);
		check_register(vertex_job_pkg::REG_CONTROL, 32'h1, "CONTROL");
		await_fetch_done(1500);
		drain_outputs(400);
		check_run_totals();

		idle_cycles(10);
		$display("Errors: %0d host value, %0d host other, %0d output value, %0d output other",
			host_value_errors, host_other_errors, output_value_errors, output_other_errors);
		if (host_value_errors + host_other_errors + output_value_errors
			+ output_other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: vertex_job.f
vertex_job_pkg.sv
vertex_table.sv
vertex_job_fifo.sv
vertex_job_filter.sv
vertex_job_config.sv
vertex_job_fetch.sv
vertex_job_unit.sv
vertex_job_tb.sv

// File: Makefile
# Verilator build for the vertex job stage

VERILATOR    ?= verilator
FILE_LIST    = vertex_job.f
TB_TOP       = vertex_job_tb
RTL_TOP      = vertex_job_unit
BUILD_DIR    = obj_dir
LINT_FLAGS   = --lint-only --timing --assert
SIM_FLAGS    = --binary --timing --assert -j 0
PASS_MESSAGE = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)
